/* hdl/pad_bridge_cfg.svh */
`ifndef PAD_BRIDGE_CFG_SVH
`define PAD_BRIDGE_CFG_SVH

// board station address, locally administered
`define PAD_MY_MAC 48'h42_04_20_42_04_20

// udp destination port that carries pad words
`define PAD_UDP_PORT 16'd42069

// number of pad ports, 1 to 8 fit the 3-bit index
`define PAD_COUNT 4

// entries per port queue, also the starting credit
`define PAD_QUEUE_DEPTH 2

`endif

/* hdl/eth_pkg.sv */
package eth_pkg;

  // one byte off the rmii receiver
  typedef logic [7:0] eth_byte_t;

  // station address, first byte on the wire in the top bits
  typedef logic [47:0] mac_t;

  // header byte index, counted after the delimiter
  typedef logic [5:0] hdr_idx_t;

  // byte offsets for ipv4/udp without vlan tag
  localparam hdr_idx_t OFF_DST_MAC   = 6'd0;
  localparam hdr_idx_t OFF_ETHERTYPE = 6'd12;
  localparam hdr_idx_t OFF_IP_PROTO  = 6'd23;
  localparam hdr_idx_t OFF_UDP_DPORT = 6'd36;
  localparam hdr_idx_t OFF_UDP_LEN   = 6'd38;
  localparam hdr_idx_t OFF_PAYLOAD   = 6'd42;

  // field values the filter accepts
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

endpackage

/* hdl/pad_pkg.sv */
package pad_pkg;

  // bit 0 goes out first, 1 means pressed
  typedef logic [7:0] buttons_t;

  // top bit of every pad word
  typedef enum logic {
    KIND_BUTTONS = 1'b0,
    KIND_TURBO   = 1'b1
  } pad_kind_e;

  // new button state for one port
  typedef struct packed {
    pad_kind_e kind;
    logic [2:0] port;
    logic [3:0] rsvd;
    buttons_t   state;
  } pad_btn_word_t;

  // turbo mask for one port
  typedef struct packed {
    pad_kind_e kind;
    logic [2:0] port;
    logic [3:0] rsvd;
    buttons_t   mask;
  } pad_turbo_word_t;

  // same 16 bits, low byte read per kind
  typedef union packed {
    pad_btn_word_t   btn;
    pad_turbo_word_t turbo;
  } pad_word_u;

endpackage

/* hdl/pad_link_if.sv */
interface pad_link_if;

  // dispatcher to port
  logic               push;
  pad_pkg::pad_word_u word;

  // port back to dispatcher, one credit per pop
  logic               credit;

  // port to status block
  logic               applied;
  pad_pkg::buttons_t  buttons;

  modport disp (
    output push,
    output word,
    input  credit
  );

  modport port (
    input  push,
    input  word,
    output credit,
    output applied,
    output buttons
  );

  modport stat (
    input applied,
    input buttons
  );

endinterface

/* hdl/rmii_rx.sv */
module rmii_rx (
  input  logic               eth_refclk,
  input  logic               sys_rst,
  input  logic [1:0]         eth_rxd,
  input  logic               eth_crsdv,
  output eth_pkg::eth_byte_t byte_data,
  output logic               byte_valid,
  output logic               frame_active
);

  // hunt preamble, then sfd, then bytes; skip waits out a bad start
  typedef enum logic [1:0] {
    S_IDLE,
    S_PRE,
    S_DATA,
    S_SKIP
  } rx_state_e;

  rx_state_e  state;
  logic [1:0] dibit_cnt;
  // three earlier dibits, newest on top
  logic [5:0] shift;
  logic       sfd_seen;

  // 11 right after 01 dibits closes the preamble
  assign sfd_seen = (state == S_PRE) && (eth_rxd == 2'b11);

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      state        <= S_IDLE;
      dibit_cnt    <= 2'd0;
      byte_valid   <= 1'b0;
      frame_active <= 1'b0;
    end else begin
      byte_valid   <= 1'b0;
      // drops the cycle after crsdv goes low
      frame_active <= eth_crsdv && ((state == S_DATA) || sfd_seen);
      if (!eth_crsdv) begin
        state <= S_IDLE;
      end else begin
        case (state)
          S_IDLE: begin
            // leading 00 dibits are allowed before the preamble
            if (eth_rxd == 2'b01) begin
              state <= S_PRE;
            end
          end
          S_PRE: begin
            if (sfd_seen) begin
              state     <= S_DATA;
              dibit_cnt <= 2'd0;
            end else if (eth_rxd != 2'b01) begin
              state <= S_SKIP;
            end
          end
          S_DATA: begin
            dibit_cnt <= dibit_cnt + 2'd1;
            // fourth dibit completes a byte
            if (dibit_cnt == 2'd3) begin
              byte_valid <= 1'b1;
            end
          end
          default: begin
            state <= S_SKIP;
          end
        endcase
      end
    end
  end

  // least significant dibit arrives first
  always_ff @(posedge eth_refclk) begin
    if (state == S_DATA) begin
      shift <= {eth_rxd, shift[5:2]};
      if (dibit_cnt == 2'd3) begin
        byte_data <= {eth_rxd, shift};
      end
    end
  end

endmodule

/* hdl/udp_word_filter.sv */
`include "pad_bridge_cfg.svh"

module udp_word_filter (
  input  logic               eth_refclk,
  input  logic               sys_rst,
  input  eth_pkg::eth_byte_t byte_data,
  input  logic               byte_valid,
  input  logic               frame_active,
  output logic               word_valid,
  output pad_pkg::pad_word_u word
);

  localparam eth_pkg::mac_t MY_MAC   = `PAD_MY_MAC;
  localparam logic [15:0]   UDP_PORT = `PAD_UDP_PORT;

  eth_pkg::eth_byte_t [5:0] mac_bytes;
  eth_pkg::hdr_idx_t        byte_idx;
  logic [2:0]               mac_pos;
  logic                     in_mac, in_payload;
  logic                     own_next, bcast_next;
  logic                     own_ok, bcast_ok;
  logic                     accept;
  eth_pkg::eth_byte_t       len_hi;
  logic [15:0]              udp_len, pay_len;
  logic [14:0]              words_left;
  logic                     hi_held;
  eth_pkg::eth_byte_t       hi_byte;

  // mac_bytes[5] is the first address byte on the wire
  assign mac_bytes  = MY_MAC;
  assign mac_pos    = 3'(byte_idx - eth_pkg::OFF_DST_MAC);
  assign in_mac     = byte_idx < (eth_pkg::OFF_DST_MAC + 6'd6);
  assign in_payload = byte_idx == eth_pkg::OFF_PAYLOAD;
  assign own_next   = own_ok && (byte_data == mac_bytes[3'd5 - mac_pos]);
  assign bcast_next = bcast_ok && (byte_data == 8'hff);
  // udp length includes its 8-byte header
  assign udp_len    = {len_hi, byte_data};
  assign pay_len    = udp_len - 16'd8;

  always_ff @(posedge eth_refclk) begin
    if (sys_rst || !frame_active) begin
      byte_idx   <= '0;
      accept     <= 1'b1;
      own_ok     <= 1'b1;
      bcast_ok   <= 1'b1;
      words_left <= '0;
      hi_held    <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (byte_valid) begin
        // index parks on the payload offset
        if (!in_payload) begin
          byte_idx <= byte_idx + 6'd1;
        end
        if (in_mac) begin
          own_ok   <= own_next;
          bcast_ok <= bcast_next;
          if ((byte_idx == eth_pkg::OFF_DST_MAC + 6'd5) && !own_next && !bcast_next) begin
            accept <= 1'b0;
          end
        end
        case (byte_idx)
          eth_pkg::OFF_ETHERTYPE: begin
            if (byte_data != eth_pkg::ETHERTYPE_IPV4[15:8]) accept <= 1'b0;
          end
          eth_pkg::OFF_ETHERTYPE + 6'd1: begin
            if (byte_data != eth_pkg::ETHERTYPE_IPV4[7:0]) accept <= 1'b0;
          end
          eth_pkg::OFF_IP_PROTO: begin
            if (byte_data != eth_pkg::IP_PROTO_UDP) accept <= 1'b0;
          end
          eth_pkg::OFF_UDP_DPORT: begin
            if (byte_data != UDP_PORT[15:8]) accept <= 1'b0;
          end
          eth_pkg::OFF_UDP_DPORT + 6'd1: begin
            if (byte_data != UDP_PORT[7:0]) accept <= 1'b0;
          end
          eth_pkg::OFF_UDP_LEN: begin
            len_hi <= byte_data;
          end
          eth_pkg::OFF_UDP_LEN + 6'd1: begin
            // short length field means no words at all
            words_left <= (udp_len > 16'd8) ? pay_len[15:1] : '0;
          end
          default: begin
          end
        endcase
        // even payload byte is held, odd one closes the word
        if (in_payload) begin
          hi_held <= !hi_held;
          if (hi_held && accept && (words_left != '0)) begin
            word_valid <= 1'b1;
            words_left <= words_left - 15'd1;
          end
        end
      end
    end
  end

  // big-endian pairing
  always_ff @(posedge eth_refclk) begin
    if (byte_valid && in_payload) begin
      if (hi_held) begin
        word <= {hi_byte, byte_data};
      end else begin
        hi_byte <= byte_data;
      end
    end
  end

endmodule

/* hdl/pad_dispatch.sv */
`include "pad_bridge_cfg.svh"

module pad_dispatch (
  input  logic               eth_refclk,
  input  logic               sys_rst,
  input  logic               word_valid,
  input  pad_pkg::pad_word_u word,
  pad_link_if.disp           links [`PAD_COUNT],
  output logic [15:0]        drop_count
);

  localparam int CW = $clog2(`PAD_QUEUE_DEPTH + 1);

  typedef logic [CW-1:0] credit_t;

  localparam credit_t FULL = credit_t'(`PAD_QUEUE_DEPTH);

  logic [`PAD_COUNT-1:0] take;
  logic                  drop;
  pad_pkg::pad_word_u    word_q;

  for (genvar i = 0; i < `PAD_COUNT; i++) begin : g_port
    credit_t credits;
    logic    hit;

    // index field sits in the same place in both views
    assign hit           = word_valid && (word.btn.port == 3'(i));
    assign take[i]       = hit && (credits != '0);
    assign links[i].word = word_q;

    always_ff @(posedge eth_refclk) begin
      if (sys_rst) begin
        credits        <= FULL;
        links[i].push  <= 1'b0;
      end else begin
        links[i].push <= take[i];
        // push and returned credit together cancel out
        if (take[i] && !links[i].credit) begin
          credits <= credits - 1'b1;
        end else if (!take[i] && links[i].credit) begin
          credits <= credits + 1'b1;
        end
      end
    end
  end

  // out-of-range index or no credit, the word is lost
  assign drop = word_valid && (take == '0);

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      drop_count <= '0;
    end else if (drop && (drop_count != 16'hffff)) begin
      drop_count <= drop_count + 16'd1;
    end
  end

  // one shared copy, only the pushed port picks it up
  always_ff @(posedge eth_refclk) begin
    if (word_valid) begin
      word_q <= word;
    end
  end

endmodule

/* hdl/pad_port.sv */
`include "pad_bridge_cfg.svh"

module pad_port (
  input  logic     eth_refclk,
  input  logic     sys_rst,
  input  logic     latch,
  input  logic     pulse,
  pad_link_if.port link,
  output logic     data
);

  localparam int DEPTH = `PAD_QUEUE_DEPTH;
  localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  pad_pkg::pad_word_u mem [DEPTH];
  pad_pkg::pad_word_u head;
  logic [PW-1:0]      wr_ptr, rd_ptr;
  logic [CW-1:0]      fill;
  // two sync flops plus one for the edge
  logic [2:0]         latch_d, pulse_d;
  logic               latch_rise, pulse_rise;
  logic               pop;
  pad_pkg::buttons_t  state, mask, shreg;
  pad_pkg::buttons_t  state_nx, mask_nx;
  logic               phase, phase_nx;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign latch_rise   = latch_d[1] && !latch_d[2];
  assign pulse_rise   = pulse_d[1] && !pulse_d[2];
  assign pop          = latch_rise && (fill != '0);
  assign head         = mem[rd_ptr];
  assign phase_nx     = !phase;
  // console line is active low
  assign data         = !shreg[0];
  assign link.buttons = state;

  // head entry takes effect on the latch that pops it
  always_comb begin
    state_nx = state;
    mask_nx  = mask;
    if (pop) begin
      if (head.btn.kind == pad_pkg::KIND_TURBO) begin
        mask_nx = head.turbo.mask;
      end else begin
        state_nx = head.btn.state;
      end
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      latch_d      <= '0;
      pulse_d      <= '0;
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      state        <= '0;
      mask         <= '0;
      phase        <= 1'b0;
      shreg        <= '0;
      link.credit  <= 1'b0;
      link.applied <= 1'b0;
    end else begin
      latch_d      <= {latch_d[1:0], latch};
      pulse_d      <= {pulse_d[1:0], pulse};
      link.credit  <= pop;
      link.applied <= pop;
      if (link.push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (link.push && !pop) begin
        fill <= fill + 1'b1;
      end else if (!link.push && pop) begin
        fill <= fill - 1'b1;
      end
      if (latch_rise) begin
        state <= state_nx;
        mask  <= mask_nx;
        phase <= phase_nx;
        // odd phase hides the turbo bits
        shreg <= phase_nx ? (state_nx & ~mask_nx) : state_nx;
      end else if (pulse_rise) begin
        shreg <= {1'b0, shreg[7:1]};
      end
    end
  end

  // dispatcher never overruns the free entries
  always_ff @(posedge eth_refclk) begin
    if (link.push) begin
      mem[wr_ptr] <= link.word;
    end
  end

endmodule

/* hdl/pad_status.sv */
`include "pad_bridge_cfg.svh"

module pad_status (
  input  logic              eth_refclk,
  input  logic              sys_rst,
  pad_link_if.stat          links [`PAD_COUNT],
  output pad_pkg::buttons_t led,
  output logic [15:0]       update_count
);

  logic [`PAD_COUNT-1:0] applied_v;
  pad_pkg::buttons_t     btn_v [`PAD_COUNT];
  pad_pkg::buttons_t     btn_or;
  logic [3:0]            n_applied;

  // flatten the interface array
  for (genvar i = 0; i < `PAD_COUNT; i++) begin : g_tap
    assign applied_v[i] = links[i].applied;
    assign btn_v[i]     = links[i].buttons;
  end

  // any pad pressed per button, plus strobes this cycle
  always_comb begin
    btn_or    = '0;
    n_applied = '0;
    for (int i = 0; i < `PAD_COUNT; i++) begin
      btn_or    = btn_or | btn_v[i];
      n_applied = n_applied + 4'(applied_v[i]);
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (sys_rst) begin
      led          <= '0;
      update_count <= '0;
    end else begin
      led          <= btn_or;
      update_count <= update_count + 16'(n_applied);
    end
  end

endmodule

/* hdl/pad_bridge_top.sv */
`include "pad_bridge_cfg.svh"

module pad_bridge_top (
  input  logic                  eth_refclk,
  input  logic                  sys_rst,
  input  logic [1:0]            eth_rxd,
  input  logic                  eth_crsdv,
  input  logic                  latch,
  input  logic                  pulse,
  output logic [`PAD_COUNT-1:0] pad_data,
  output pad_pkg::buttons_t     led,
  output logic [15:0]           update_count,
  output logic [15:0]           drop_count
);

  eth_pkg::eth_byte_t byte_data;
  logic               byte_valid;
  logic               frame_active;
  logic               word_valid;
  pad_pkg::pad_word_u word;

  // one link per pad port
  pad_link_if links [`PAD_COUNT] ();

  // rmii dibits into bytes
  rmii_rx u_rmii_rx (
    .eth_refclk   (eth_refclk),
    .sys_rst      (sys_rst),
    .eth_rxd      (eth_rxd),
    .eth_crsdv    (eth_crsdv),
    .byte_data    (byte_data),
    .byte_valid   (byte_valid),
    .frame_active (frame_active)
  );

  // header checks, udp payload into words
  udp_word_filter u_udp_word_filter (
    .eth_refclk   (eth_refclk),
    .sys_rst      (sys_rst),
    .byte_data    (byte_data),
    .byte_valid   (byte_valid),
    .frame_active (frame_active),
    .word_valid   (word_valid),
    .word         (word)
  );

  pad_dispatch u_pad_dispatch (
    .eth_refclk (eth_refclk),
    .sys_rst    (sys_rst),
    .word_valid (word_valid),
    .word       (word),
    .links      (links),
    .drop_count (drop_count)
  );

  // latch and pulse are shared by every port
  for (genvar i = 0; i < `PAD_COUNT; i++) begin : g_pad
    pad_port u_pad_port (
      .eth_refclk (eth_refclk),
      .sys_rst    (sys_rst),
      .latch      (latch),
      .pulse      (pulse),
      .link       (links[i]),
      .data       (pad_data[i])
    );
  end

  pad_status u_pad_status (
    .eth_refclk   (eth_refclk),
    .sys_rst      (sys_rst),
    .links        (links),
    .led          (led),
    .update_count (update_count)
  );

endmodule

/* tests/pad_bridge_tb.sv */
`include "pad_bridge_cfg.svh"

module pad_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP = `PAD_COUNT;
  localparam int DEPTH = `PAD_QUEUE_DEPTH;
  localparam int N_RANDOM = 40;
  // random frames plus directed ones
  localparam int N_FRAMES = N_RANDOM + 8;
  localparam logic [47:0] MY_MAC = `PAD_MY_MAC;
  localparam logic [47:0] BCAST = 48'hffff_ffff_ffff;
  localparam logic [15:0] MY_PORT = `PAD_UDP_PORT;

  logic eth_refclk;
  logic sys_rst;
  logic [1:0] eth_rxd;
  logic eth_crsdv;
  logic latch;
  logic pulse;
  logic [NP-1:0] pad_data;
  pad_pkg::buttons_t led;
  logic [15:0] update_count;
  logic [15:0] drop_count;

  logic [31:0] rng_state;
  string test_name;
  logic [7:0] frame_q [$];
  logic [15:0] payload_q [$];

  // reference model, one small queue per port
  logic [15:0] mq [NP][DEPTH];
  int mq_n [NP];
  logic [7:0] m_state [NP];
  logic [7:0] m_mask [NP];
  logic m_phase [NP];
  logic [7:0] m_shown [NP];
  int m_drops;
  int m_pops;

  pad_bridge_top u_pad_bridge_top (
    .eth_refclk   (eth_refclk),
    .sys_rst      (sys_rst),
    .eth_rxd      (eth_rxd),
    .eth_crsdv    (eth_crsdv),
    .latch        (latch),
    .pulse        (pulse),
    .pad_data     (pad_data),
    .led          (led),
    .update_count (update_count),
    .drop_count   (drop_count)
  );

  // 8 ns period
  initial begin
    eth_refclk = 1'b0;
    forever #4 eth_refclk = ~eth_refclk;
  end

  // budget per frame, generous against reads and gaps
  initial begin
    repeat (N_FRAMES * 4000) @(posedge eth_refclk);
    $display("watchdog expired after %0d frame budgets", N_FRAMES);
    $display("SIMULATION FAILED");
    $fatal(1, "simulation timed out");
  end

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // kind, port index, random reserved nibble, low byte
  function automatic logic [15:0] pack_word(input logic kind, input logic [2:0] port,
                                            input logic [7:0] low);
    logic [31:0] r;
    r = next_random();
    return {kind, port, r[3:0], low};
  endfunction

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch in %s", test_name);
    end
  endtask

  // out of range or full queue means a drop
  task automatic model_push(input logic [15:0] w);
    int p;
    p = int'(w[14:12]);
    if (p >= NP || mq_n[p] >= DEPTH) begin
      m_drops++;
    end else begin
      mq[p][mq_n[p]] = w;
      mq_n[p]++;
    end
  endtask

  // one console latch on every port
  task automatic model_latch();
    logic [15:0] w;
    for (int p = 0; p < NP; p++) begin
      if (mq_n[p] > 0) begin
        w = mq[p][0];
        for (int i = 1; i < DEPTH; i++) begin
          mq[p][i-1] = mq[p][i];
        end
        mq_n[p]--;
        m_pops++;
        if (w[15]) begin
          m_mask[p] = w[7:0];
        end else begin
          m_state[p] = w[7:0];
        end
      end
      m_phase[p] = !m_phase[p];
      // odd phase shows turbo buttons released
      m_shown[p] = m_phase[p] ? (m_state[p] & ~m_mask[p]) : m_state[p];
    end
  endtask

  // rmii sends the low dibit first
  task automatic send_byte(input logic [7:0] b);
    for (int i = 0; i < 4; i++) begin
      @(negedge eth_refclk);
      eth_crsdv = 1'b1;
      eth_rxd   = b[2*i +: 2];
    end
  endtask

  // frame around payload_q, then a 12 cycle gap
  task automatic send_frame(input logic [47:0] dst, input logic [15:0] etype,
                            input logic [7:0] proto, input logic [15:0] dport);
    logic [15:0] udp_len;
    logic [15:0] ip_len;
    logic accepted;
    frame_q.delete();
    udp_len = 16'(8 + 2 * payload_q.size());
    ip_len  = udp_len + 16'd20;
    for (int i = 5; i >= 0; i--) begin
      frame_q.push_back(dst[8*i +: 8]);
    end
    // random source address
    for (int i = 0; i < 6; i++) begin
      frame_q.push_back(8'(next_random()));
    end
    frame_q.push_back(etype[15:8]);
    frame_q.push_back(etype[7:0]);
    // ipv4 header, only protocol matters to the filter
    for (int i = 0; i < 20; i++) begin
      case (i)
        0: frame_q.push_back(8'h45);
        2: frame_q.push_back(ip_len[15:8]);
        3: frame_q.push_back(ip_len[7:0]);
        8: frame_q.push_back(8'h40);
        9: frame_q.push_back(proto);
        default: frame_q.push_back(8'h00);
      endcase
    end
    // udp header at byte 34
    frame_q.push_back(8'(next_random()));
    frame_q.push_back(8'(next_random()));
    frame_q.push_back(dport[15:8]);
    frame_q.push_back(dport[7:0]);
    frame_q.push_back(udp_len[15:8]);
    frame_q.push_back(udp_len[7:0]);
    frame_q.push_back(8'h00);
    frame_q.push_back(8'h00);
    foreach (payload_q[i]) begin
      frame_q.push_back(payload_q[i][15:8]);
      frame_q.push_back(payload_q[i][7:0]);
    end
    // fake fcs, must not turn into words
    for (int i = 0; i < 4; i++) begin
      frame_q.push_back(8'(next_random()));
    end
    // preamble ends in the 11 delimiter dibit
    repeat (7) send_byte(8'h55);
    send_byte(8'hd5);
    foreach (frame_q[i]) begin
      send_byte(frame_q[i]);
    end
    @(negedge eth_refclk);
    eth_crsdv = 1'b0;
    eth_rxd   = 2'b00;
    repeat (11) @(negedge eth_refclk);
    accepted = (dst == MY_MAC || dst == BCAST) && etype == 16'h0800 &&
               proto == 8'd17 && dport == MY_PORT;
    if (accepted) begin
      foreach (payload_q[i]) begin
        model_push(payload_q[i]);
      end
    end
    payload_q.delete();
  endtask

  // latch, then 8 data bits with pulses; data is active low
  task automatic console_read();
    logic [NP-1:0] exp;
    logic [7:0] led_exp;
    model_latch();
    @(negedge eth_refclk);
    latch = 1'b1;
    repeat (6) @(negedge eth_refclk);
    latch = 1'b0;
    for (int b = 0; b < 8; b++) begin
      for (int p = 0; p < NP; p++) begin
        exp[p] = !m_shown[p][b];
      end
      check($sformatf("pad_data bit %0d", b), 32'(exp), 32'(pad_data));
      pulse = 1'b1;
      repeat (4) @(negedge eth_refclk);
      pulse = 1'b0;
      repeat (4) @(negedge eth_refclk);
    end
    // register emptied, line idles high
    check("pad_data after 8 pulses", 32'({NP{1'b1}}), 32'(pad_data));
    led_exp = 8'h00;
    for (int p = 0; p < NP; p++) begin
      led_exp = led_exp | m_state[p];
    end
    check("led", 32'(led_exp), 32'(led));
    check("update_count", 32'(m_pops), 32'(update_count));
    check("drop_count", 32'(m_drops), 32'(drop_count));
  endtask

  initial begin
    logic [31:0] r;
    int nwords;
    int port;
    int drops_before;
    logic [47:0] dst;
    logic [15:0] etype;
    logic [7:0] proto;
    logic [15:0] dport;
    rng_state = 32'h629edb95;
    eth_rxd   = 2'b00;
    eth_crsdv = 1'b0;
    latch     = 1'b0;
    pulse     = 1'b0;
    sys_rst   = 1'b1;
    for (int p = 0; p < NP; p++) begin
      mq_n[p]    = 0;
      m_state[p] = 8'h00;
      m_mask[p]  = 8'h00;
      m_phase[p] = 1'b0;
      m_shown[p] = 8'h00;
    end
    m_drops = 0;
    m_pops  = 0;
    test_name = "reset";
    repeat (8) @(negedge eth_refclk);
    sys_rst = 1'b0;
    @(negedge eth_refclk);
    check("pad_data", 32'({NP{1'b1}}), 32'(pad_data));
    check("led", 32'h0, 32'(led));
    check("update_count", 32'h0, 32'(update_count));
    check("drop_count", 32'h0, 32'(drop_count));

    // random words, some to missing ports, some turbo
    test_name = "random_words";
    for (int f = 0; f < N_RANDOM; f++) begin
      r = next_random();
      nwords = 1 + int'(r[3:0]) % 5;
      dst = r[4] ? BCAST : MY_MAC;
      for (int i = 0; i < nwords; i++) begin
        r = next_random();
        port = (r[10:8] == 3'd0) ? int'(r[2:0]) : int'(r[2:0]) % NP;
        payload_q.push_back(pack_word(r[14:12] == 3'd0, 3'(port), r[23:16]));
      end
      send_frame(dst, 16'h0800, 8'd17, MY_PORT);
      check("drop_count after frame", 32'(m_drops), 32'(drop_count));
      r = next_random();
      repeat (int'(r[7:0]) % 3) console_read();
    end

    // each bad field alone, then broadcast and own address
    test_name = "header_filter";
    console_read();
    console_read();
    for (int k = 0; k < 6; k++) begin
      dst   = (k == 4) ? BCAST : MY_MAC;
      etype = 16'h0800;
      proto = 8'd17;
      dport = MY_PORT;
      case (k)
        0: dst = MY_MAC ^ 48'h1;
        1: etype = 16'h86dd;
        2: proto = 8'd6;
        3: dport = MY_PORT ^ 16'h0100;
        default: begin
        end
      endcase
      r = next_random();
      payload_q.push_back(pack_word(1'b0, 3'(k % NP), r[7:0]));
      payload_q.push_back(pack_word(1'b0, 3'((k + 1) % NP), r[15:8]));
      send_frame(dst, etype, proto, dport);
      check("drop_count after frame", 32'(m_drops), 32'(drop_count));
      console_read();
    end

    // third word finds no credit
    test_name = "credit_overflow";
    console_read();
    console_read();
    r = next_random();
    port = int'(r[2:0]) % NP;
    for (int i = 0; i < 3; i++) begin
      r = next_random();
      payload_q.push_back(pack_word(1'b0, 3'(port), r[7:0]));
    end
    drops_before = m_drops;
    send_frame(MY_MAC, 16'h0800, 8'd17, MY_PORT);
    check("drop_count one higher", 32'(drops_before + 1), 32'(drop_count));
    console_read();
    console_read();
    console_read();

    // pressed and masked buttons blink on alternate latches
    test_name = "turbo";
    console_read();
    console_read();
    r = next_random();
    port = int'(r[2:0]) % NP;
    payload_q.push_back(pack_word(1'b0, 3'(port), r[15:8] | 8'h81));
    payload_q.push_back(pack_word(1'b1, 3'(port), r[23:16] | 8'h01));
    send_frame(BCAST, 16'h0800, 8'd17, MY_PORT);
    repeat (6) console_read();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/eth_pkg.sv
hdl/pad_pkg.sv
hdl/pad_link_if.sv
hdl/rmii_rx.sv
hdl/udp_word_filter.sv
hdl/pad_dispatch.sv
hdl/pad_port.sv
hdl/pad_status.sv
hdl/pad_bridge_top.sv
tests/pad_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pad bridge testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module pad_bridge_tb \
  --Mdir obj_dir -o pad_bridge_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/pad_bridge_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
